// File: project.f
rtl/tetris_pkg.sv
rtl/piece_rotator.sv
rtl/collision_checker.sv
rtl/pixel_hit.sv
rtl/piece_controller.sv
rtl/piece_top.sv
tb/piece_top_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the piece unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module piece_top_tb -o piece_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/piece_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi

if ! grep -q "Test completed successfully" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0

// File: tb/piece_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module piece_top_tb;

    import tetris_pkg::*;

    typedef struct
    {
        int   grp;
        int   bsel;
        bit   spn;
        key_t key;
        int   ticks;
        int   col;
        int   row;
        bit   lnd;
        bit   ovr;
    } step_t;

    logic    Clk;
    logic    arst_n;
    logic    frame_tick;
    logic    spawn;
    key_t    key_code;
    mask_t   piece_new;
    sprite_t sprite_new;
    board_t  board;
    pix_t    draw_x;
    pix_t    draw_y;
    mask_t   piece_mask;
    col_t    piece_col;
    row_t    piece_row;
    sprite_t sprite_index;
    logic    draw_piece;
    logic    landed;
    logic    game_over;

    step_t   steps[$];
    mask_t   exp_mask;
    sprite_t exp_sprite;
    bit      exp_over;
    bit      key_armed;
    int      last_col;
    int      last_row;
    int      errors = 0;
    int      test_errors = 0;
    int      tests_run = 0;
    int      tests_failed = 0;

    piece_top uut (.*);

    initial
    begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    // Watchdog for the whole run.
    initial
    begin
        #2000000;
        $display("Timeout: the simulation ran past its time limit");
        $display("Test failed");
        $finish;
    end

    // ****************************************
    // Reference model
    // ****************************************

    function automatic mask_t rotate_cw(input mask_t m);
        mask_t o;
        for (int r = 0; r < 4; r++)
            for (int c = 0; c < 4; c++)
                o[r*4 + c] = m[(3 - c)*4 + r];
        return o;
    endfunction

    // Three clockwise turns give one counter-clockwise turn.
    function automatic mask_t rotate_ccw(input mask_t m);
        return rotate_cw(rotate_cw(rotate_cw(m)));
    endfunction

    function automatic bit shape_fits(input mask_t m, input int col, input int row,
                                      input board_t b);
        int bc;
        int br;
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < 16; i++)
        begin
            bc = col + i % 4;
            br = row + i / 4;
            if (m[i])
            begin
                if (bc < 0 || bc > 11 || br > 19)
                    ok = 1'b0;
                else if (b[br*12 + bc])
                    ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // Find the board cell under the pixel, then the mask cell under it.
    function automatic bit pixel_in_piece(input int x, input int y, input mask_t m,
                                          input int col, input int row);
        int cx;
        int cy;
        int mr;
        int mc;
        if (x < 140 || y < 0)
            return 1'b0;
        cx = (x - 140) / 20;
        cy = y / 20;
        mr = cy - row;
        mc = cx - col;
        if (cx > 11 || cy > 19 || mr < 0 || mr > 3 || mc < 0 || mc > 3)
            return 1'b0;
        return m[mr*4 + mc];
    endfunction

    function automatic board_t board_of(input int sel);
        board_t b;
        b = '0;
        if (sel == 1)
            for (int c = 4; c < 12; c++)
                b[19*12 + c] = 1'b1;         // Ledge with an empty gap at the left.
        else if (sel == 2)
            for (int i = 0; i < 36; i++)
                b[i] = 1'b1;                 // Top three rows full.
        return b;
    endfunction

    // ****************************************
    // Stimulus helpers
    // ****************************************

    task automatic wait_clocks(input int n);
        int guard;
        guard = 0;
        while (guard < n)
        begin
            @(negedge Clk);
            guard++;
        end
    endtask

    task automatic pulse_tick();
        frame_tick = 1'b1;
        wait_clocks(3);
        frame_tick = 1'b0;
        wait_clocks(5);
    endtask

    task automatic add_step(input int g, input int bs, input bit sp, input key_t k,
                            input int t, input int c, input int r, input bit l,
                            input bit o);
        step_t s;
        s = '{g, bs, sp, k, t, c, r, l, o};
        steps.push_back(s);
    endtask

    task automatic log_error(input string what);
        $display("[ERROR] %0d ns: %s", $time, what);
        errors++;
        test_errors++;
    endtask

    task automatic close_test(input int g);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("Test %0d finished with %0d errors", g, test_errors);
        test_errors = 0;
    endtask

    task automatic apply_step(input step_t s);
        board_t b;
        mask_t  rot;
        int     col_before;
        int     row_before;
        int     exp_col;
        b          = board_of(s.bsel);
        board      = b;
        key_code   = s.key;
        col_before = last_col;
        row_before = last_row;
        if (s.spn)
        begin
            sprite_new = sprite_new + sprite_t'(1);  // Each spawn brings a new sprite.
            spawn = 1'b1;
            wait_clocks(1);
            spawn = 1'b0;
            if (!exp_over)
            begin
                exp_mask   = piece_new;
                exp_sprite = sprite_new;
                col_before = int'(SPAWN_COL);
                row_before = int'(SPAWN_ROW);
            end
            wait_clocks(1);
        end
        for (int t = 0; t < s.ticks; t++)
            pulse_tick();
        if (s.ticks > 0)
        begin
            // An armed press acts on the first tick, at the position before it.
            if (s.key == KEY_LEFT && key_armed)
            begin
                exp_col = col_before;
                if (shape_fits(exp_mask, col_before - 1, row_before, b))
                begin
                    exp_col   = col_before - 1;
                    key_armed = 1'b0;
                end
                if (int'(piece_col) != exp_col)
                    log_error($sformatf("col %0d after a left press, model expects %0d",
                                        int'(piece_col), exp_col));
            end
            else if ((s.key == KEY_CW || s.key == KEY_CCW) && key_armed)
            begin
                rot = (s.key == KEY_CW) ? rotate_cw(exp_mask) : rotate_ccw(exp_mask);
                if (shape_fits(rot, col_before, row_before, b))
                begin
                    exp_mask  = rot;
                    key_armed = 1'b0;
                end
            end
            else if (s.key == 8'h00)
                key_armed = 1'b1;
        end
        if (int'(piece_col) != s.col)
            log_error($sformatf("col %0d, expected %0d", int'(piece_col), s.col));
        if (int'(piece_row) != s.row)
            log_error($sformatf("row %0d, expected %0d", piece_row, s.row));
        if (piece_mask != exp_mask)
            log_error($sformatf("mask %h, expected %h", piece_mask, exp_mask));
        if (sprite_index != exp_sprite)
            log_error($sformatf("sprite %0d, expected %0d", sprite_index, exp_sprite));
        if (landed != s.lnd)
            log_error($sformatf("landed %b, expected %b", landed, s.lnd));
        if (game_over != s.ovr)
            log_error($sformatf("game_over %b, expected %b", game_over, s.ovr));
        last_col = s.col;
        last_row = s.row;
        exp_over = s.ovr;
    endtask

    // ****************************************
    // Main sequence
    // ****************************************

    initial
    begin
        int px[8];
        int py[8];
        bit exp_hit;
        arst_n     = 1'b0;
        frame_tick = 1'b0;
        spawn      = 1'b0;
        key_code   = '0;
        piece_new  = 16'h00F0;
        sprite_new = 6'd5;
        board      = '0;
        draw_x     = '0;
        draw_y     = '0;
        exp_mask   = '0;
        exp_sprite = '0;
        exp_over   = 1'b0;
        key_armed  = 1'b1;
        last_col   = int'(SPAWN_COL);
        last_row   = int'(SPAWN_ROW);
        px = '{220, 219, 299, 300, 250, 250, 140, 260};
        py = '{20, 20, 39, 39, 19, 40, 0, 30};

        add_step(1, 0, 1, 0, 0, 4, 0, 0, 0);
        add_step(1, 0, 0, 0, 3, 4, 3, 0, 0);
        add_step(2, 0, 0, KEY_LEFT, 1, 3, 3, 0, 0);
        add_step(2, 0, 0, KEY_LEFT, 1, 3, 4, 0, 0);
        add_step(2, 0, 0, 0, 1, 3, 5, 0, 0);
        add_step(2, 0, 0, KEY_LEFT, 1, 2, 5, 0, 0);
        add_step(2, 0, 0, 0, 1, 2, 6, 0, 0);
        add_step(2, 0, 0, KEY_LEFT, 1, 1, 6, 0, 0);
        add_step(2, 0, 0, 0, 1, 1, 7, 0, 0);
        add_step(2, 0, 0, KEY_LEFT, 1, 0, 7, 0, 0);
        add_step(2, 0, 0, 0, 1, 0, 8, 0, 0);
        add_step(2, 0, 0, KEY_LEFT, 1, 0, 9, 0, 0);
        add_step(3, 0, 0, KEY_CW, 1, 0, 9, 0, 0);
        add_step(3, 0, 0, 0, 1, 0, 10, 0, 0);
        add_step(3, 0, 0, KEY_CCW, 1, 0, 10, 0, 0);
        add_step(3, 0, 0, 0, 1, 0, 11, 0, 0);
        add_step(3, 0, 0, KEY_CCW, 1, 0, 11, 0, 0);
        add_step(3, 0, 0, 0, 1, 0, 12, 0, 0);
        add_step(3, 0, 0, KEY_LEFT, 1, -1, 12, 0, 0);
        add_step(3, 0, 0, 0, 1, -1, 13, 0, 0);
        add_step(3, 0, 0, KEY_CW, 1, -1, 14, 0, 0);
        add_step(4, 1, 1, 0, 0, 4, 0, 0, 0);
        add_step(4, 1, 0, 0, 17, 4, 17, 0, 0);
        add_step(4, 1, 0, 0, LOCK_TICKS, 4, 17, 0, 0);
        add_step(4, 1, 0, 0, 1, 4, 17, 1, 0);
        add_step(4, 1, 1, 0, 0, 4, 0, 0, 0);
        add_step(4, 1, 0, 0, 18, 4, 17, 0, 0);
        for (int c = 3; c >= 0; c--)
        begin
            add_step(4, 1, 0, KEY_LEFT, 1, c, 17, 0, 0);
            add_step(4, 1, 0, 0, 1, c, 17, 0, 0);
        end
        add_step(4, 1, 0, 0, 1, 0, 18, 0, 0);
        add_step(5, 2, 1, 0, 0, 4, 0, 0, 0);
        add_step(5, 2, 0, 0, 1, 4, 0, 1, 1);
        add_step(5, 2, 1, 0, 0, 4, 0, 1, 1);
        add_step(5, 2, 0, 0, 2, 4, 0, 1, 1);

        wait_clocks(10);
        arst_n = 1'b1;
        wait_clocks(2);

        foreach (steps[i])
        begin
            apply_step(steps[i]);
            if (i == steps.size() - 1 || steps[i + 1].grp != steps[i].grp)
                close_test(steps[i].grp);
        end

        // Pixel points around the piece left at the spawn position.
        for (int i = 0; i < 8; i++)
        begin
            draw_x = pix_t'(px[i]);
            draw_y = pix_t'(py[i]);
            wait_clocks(1);
            exp_hit = pixel_in_piece(px[i], py[i], exp_mask, last_col, last_row);
            if (draw_piece != exp_hit)
                log_error($sformatf("draw_piece %b at (%0d,%0d), expected %b",
                                    draw_piece, px[i], py[i], exp_hit));
        end
        close_test(6);

        arst_n = 1'b0;
        wait_clocks(10);
        arst_n = 1'b1;
        wait_clocks(2);
        if (landed != 1'b1 || game_over != 1'b0)
            log_error($sformatf("landed %b, game_over %b after reset", landed, game_over));
        if (piece_mask != '0)
            log_error($sformatf("mask %h after reset, expected 0000", piece_mask));
        close_test(7);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/piece_top.sv
`timescale 1ns/1ps
`default_nettype none

module piece_top
(
    input  logic                Clk,
    input  logic                arst_n,
    input  logic                frame_tick,
    input  logic                spawn,
    input  tetris_pkg::key_t    key_code,
    input  tetris_pkg::mask_t   piece_new,
    input  tetris_pkg::sprite_t sprite_new,
    input  tetris_pkg::board_t  board,
    input  tetris_pkg::pix_t    draw_x,
    input  tetris_pkg::pix_t    draw_y,
    output tetris_pkg::mask_t   piece_mask,
    output tetris_pkg::col_t    piece_col,
    output tetris_pkg::row_t    piece_row,
    output tetris_pkg::sprite_t sprite_index,
    output logic                draw_piece,
    output logic                landed,
    output logic                game_over
);

    import tetris_pkg::*;

    mask_t mask_cw, mask_ccw;
    logic  can_left, can_right, can_down;
    logic  fits_cw, fits_ccw;

    // ****************************************
    // Controller and rotation
    // ****************************************

    piece_controller u_ctrl (
        .Clk, .arst_n, .frame_tick, .spawn, .key_code,
        .piece_new, .sprite_new,
        .mask_cw, .mask_ccw,
        .can_left, .can_right, .can_down, .fits_cw, .fits_ccw,
        .piece_mask, .piece_col, .piece_row, .sprite_index,
        .landed, .game_over
    );

    piece_rotator u_rot (.mask(piece_mask), .mask_cw, .mask_ccw);

    // ****************************************
    // Collision checks
    // ****************************************

    collision_checker cur_chk (
        .mask(piece_mask), .col(piece_col), .row(piece_row), .board,
        .can_left, .can_right, .can_down, .fits()
    );

    // Rotated shapes only need the in-place fit.
    collision_checker cw_chk (
        .mask(mask_cw), .col(piece_col), .row(piece_row), .board,
        .can_left(), .can_right(), .can_down(), .fits(fits_cw)
    );

    collision_checker ccw_chk (
        .mask(mask_ccw), .col(piece_col), .row(piece_row), .board,
        .can_left(), .can_right(), .can_down(), .fits(fits_ccw)
    );

    pixel_hit u_pix (
        .draw_x, .draw_y,
        .mask(piece_mask), .col(piece_col), .row(piece_row),
        .draw_piece
    );

endmodule

`default_nettype wire

// File: rtl/piece_controller.sv
`timescale 1ns/1ps
`default_nettype none

module piece_controller
(
    input  logic                Clk,
    input  logic                arst_n,
    input  logic                frame_tick,
    input  logic                spawn,
    input  tetris_pkg::key_t    key_code,
    input  tetris_pkg::mask_t   piece_new,
    input  tetris_pkg::sprite_t sprite_new,
    input  tetris_pkg::mask_t   mask_cw,
    input  tetris_pkg::mask_t   mask_ccw,
    input  logic                can_left,
    input  logic                can_right,
    input  logic                can_down,
    input  logic                fits_cw,
    input  logic                fits_ccw,
    output tetris_pkg::mask_t   piece_mask,
    output tetris_pkg::col_t    piece_col,
    output tetris_pkg::row_t    piece_row,
    output tetris_pkg::sprite_t sprite_index,
    output logic                landed,
    output logic                game_over
);

    import tetris_pkg::*;

    piece_state_t state, state_next;
    mask_t        mask_next;
    col_t         col_next;
    row_t         row_next;
    sprite_t      sprite_next;
    lock_cnt_t    lock_cnt, lock_next;
    logic         armed, armed_next;
    logic         tick_s1, tick_s2, tick_d;
    logic         tick_rise;
    logic         key_left, key_right, key_ccw, key_cw, key_action;

    // ****************************************
    // Frame tick synchronizer
    // ****************************************

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            tick_s1 <= 1'b0;
            tick_s2 <= 1'b0;
            tick_d  <= 1'b0;
        end
        else
        begin
            tick_s1 <= frame_tick;
            tick_s2 <= tick_s1;
            tick_d  <= tick_s2;
        end
    end

    assign tick_rise = tick_s2 & ~tick_d;    // One cycle per frame.

    assign key_left   = (key_code == KEY_LEFT);
    assign key_right  = (key_code == KEY_RIGHT);
    assign key_ccw    = (key_code == KEY_CCW);
    assign key_cw     = (key_code == KEY_CW);
    assign key_action = key_left | key_right | key_ccw | key_cw;

    // ****************************************
    // Piece state machine
    // ****************************************

    always_comb
    begin : next_state
        logic acted;
        acted       = 1'b0;
        state_next  = state;
        mask_next   = piece_mask;
        col_next    = piece_col;
        row_next    = piece_row;
        sprite_next = sprite_index;
        lock_next   = lock_cnt;
        armed_next  = armed;

        if (spawn && (state != ST_OVER))
        begin
            mask_next   = piece_new;
            sprite_next = sprite_new;
            col_next    = SPAWN_COL;
            row_next    = SPAWN_ROW;
            state_next  = ST_FALL;
        end
        else if (tick_rise)
        begin
            if (!key_action)
                armed_next = 1'b1;           // Key released, next press may act.
            case (state)
                ST_FALL:
                begin
                    if (!can_down)
                    begin
                        if (piece_row == SPAWN_ROW)
                            state_next = ST_OVER;  // No room below the spawn row.
                        else
                        begin
                            state_next = ST_LOCK;
                            lock_next  = lock_cnt_t'(LOCK_TICKS - 1);
                        end
                    end
                    else
                    begin
                        if (armed && key_left && can_left)
                        begin
                            col_next = piece_col - col_t'(1);
                            acted    = 1'b1;
                        end
                        else if (armed && key_right && can_right)
                        begin
                            col_next = piece_col + col_t'(1);
                            acted    = 1'b1;
                        end
                        else if (armed && key_ccw && fits_ccw)
                        begin
                            mask_next = mask_ccw;
                            acted     = 1'b1;
                        end
                        else if (armed && key_cw && fits_cw)
                        begin
                            mask_next = mask_cw;
                            acted     = 1'b1;
                        end
                        if (acted)
                            armed_next = 1'b0;
                        else
                            row_next = piece_row + row_t'(1);  // Gravity.
                    end
                end
                ST_LOCK:
                begin
                    if (can_down)
                        state_next = ST_FALL;    // Slid off a ledge.
                    else if (lock_cnt == '0)
                        state_next = ST_LANDED;
                    else
                    begin
                        if (armed && key_left && can_left)
                        begin
                            col_next   = piece_col - col_t'(1);
                            armed_next = 1'b0;
                        end
                        else if (armed && key_right && can_right)
                        begin
                            col_next   = piece_col + col_t'(1);
                            armed_next = 1'b0;
                        end
                        lock_next = lock_cnt - lock_cnt_t'(1);
                    end
                end
                default:
                begin
                    state_next = state;      // Ticks are ignored once landed.
                end
            endcase
        end
    end

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state        <= ST_LANDED;
            piece_mask   <= '0;
            piece_col    <= SPAWN_COL;
            piece_row    <= SPAWN_ROW;
            sprite_index <= '0;
            lock_cnt     <= '0;
            armed        <= 1'b1;
        end
        else
        begin
            state        <= state_next;
            piece_mask   <= mask_next;
            piece_col    <= col_next;
            piece_row    <= row_next;
            sprite_index <= sprite_next;
            lock_cnt     <= lock_next;
            armed        <= armed_next;
        end
    end

    assign landed    = (state == ST_LANDED) || (state == ST_OVER);
    assign game_over = (state == ST_OVER);

endmodule

`default_nettype wire

// File: rtl/pixel_hit.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_hit
(
    input  tetris_pkg::pix_t  draw_x,
    input  tetris_pkg::pix_t  draw_y,
    input  tetris_pkg::mask_t mask,
    input  tetris_pkg::col_t  col,
    input  tetris_pkg::row_t  row,
    output logic              draw_piece
);

    import tetris_pkg::*;

    always_comb
    begin : hit_scan
        int bc;
        int br;
        int x0;
        int y0;
        draw_piece = 1'b0;
        for (int i = 0; i < 16; i++)
        begin
            bc = int'(col) + (i % 4);
            br = int'(row) + (i / 4);
            x0 = BOARD_X0 + bc*CELL_PX;      // Top left pixel of this cell.
            y0 = BOARD_Y0 + br*CELL_PX;
            // Cells hanging outside the board are never drawn.
            if (mask[i] && (bc >= 0) && (bc < BOARD_COLS) && (br < BOARD_ROWS))
            begin
                if ((int'(draw_x) >= x0) && (int'(draw_x) < x0 + CELL_PX) &&
                    (int'(draw_y) >= y0) && (int'(draw_y) < y0 + CELL_PX))
                begin
                    draw_piece = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/collision_checker.sv
`timescale 1ns/1ps
`default_nettype none

module collision_checker
(
    input  tetris_pkg::mask_t  mask,
    input  tetris_pkg::col_t   col,
    input  tetris_pkg::row_t   row,
    input  tetris_pkg::board_t board,
    output logic               can_left,
    output logic               can_right,
    output logic               can_down,
    output logic               fits
);

    import tetris_pkg::*;

    logic [3:0] blk;                         // Any cell blocked: stay, left, right, down.

    // A cell is blocked outside the walls, below the floor or on a settled cell.
    function automatic logic cell_blocked(input int bc, input int br, input board_t b);
        logic hit;
        hit = 1'b0;
        if ((bc < 0) || (bc >= BOARD_COLS) || (br < 0) || (br >= BOARD_ROWS))
        begin
            hit = 1'b1;
        end
        else if (b[br*BOARD_COLS + bc])
        begin
            hit = 1'b1;
        end
        return hit;
    endfunction

    // ****************************************
    // Scan all 16 cells at four offsets
    // ****************************************

    always_comb
    begin : scan
        int bc;
        int br;
        blk = 4'b0000;
        for (int i = 0; i < 16; i++)
        begin
            bc = int'(col) + (i % 4);        // Signed column of this cell.
            br = int'(row) + (i / 4);
            if (mask[i])
            begin
                if (cell_blocked(bc, br, board))
                begin
                    blk[0] = 1'b1;
                end
                if (cell_blocked(bc - 1, br, board))
                begin
                    blk[1] = 1'b1;
                end
                if (cell_blocked(bc + 1, br, board))
                begin
                    blk[2] = 1'b1;
                end
                if (cell_blocked(bc, br + 1, board))
                begin
                    blk[3] = 1'b1;
                end
            end
        end
    end

    assign fits      = ~blk[0];
    assign can_left  = ~blk[1];
    assign can_right = ~blk[2];
    assign can_down  = ~blk[3];

endmodule

`default_nettype wire

// File: rtl/piece_rotator.sv
`timescale 1ns/1ps
`default_nettype none

module piece_rotator
(
    input  tetris_pkg::mask_t mask,
    output tetris_pkg::mask_t mask_cw,
    output tetris_pkg::mask_t mask_ccw
);

    // Clockwise: new cell (r, c) takes old cell (3-c, r).
    always_comb
    begin
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                mask_cw[r*4 + c] = mask[(3 - c)*4 + r];
            end
        end
    end

    // Counter-clockwise is the inverse, new cell (r, c) takes old cell (c, 3-r).
    always_comb
    begin
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                mask_ccw[r*4 + c] = mask[c*4 + (3 - r)];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/tetris_pkg.sv
`default_nettype none

package tetris_pkg;

    // ****************************************
    // Vector types
    // ****************************************

    typedef logic [15:0]        mask_t;      // 4x4 shape, bit r*4+c.
    typedef logic [239:0]       board_t;     // Settled cells, bit r*12+c.
    typedef logic signed [4:0]  col_t;       // Left mask edge, may hang past the wall.
    typedef logic [5:0]         row_t;       // Top mask edge.
    typedef logic [9:0]         pix_t;
    typedef logic [7:0]         key_t;
    typedef logic [5:0]         sprite_t;
    typedef logic [4:0]         lock_cnt_t;

    typedef enum logic [1:0]
    {
        ST_FALL,
        ST_LOCK,
        ST_LANDED,
        ST_OVER
    } piece_state_t;

    // ****************************************
    // Board geometry
    // ****************************************

    localparam int BOARD_COLS = 12;
    localparam int BOARD_ROWS = 20;
    localparam int CELL_PX    = 20;
    localparam int BOARD_X0   = 140;         // Left pixel edge of the board.
    localparam int BOARD_Y0   = 0;

    localparam col_t SPAWN_COL = 5'sd4;
    localparam row_t SPAWN_ROW = 6'd0;

    // ****************************************
    // Timing and keys
    // ****************************************

    localparam int LOCK_TICKS = 32;          // Frames a resting piece may still slide.

    localparam key_t KEY_LEFT  = 8'h04;
    localparam key_t KEY_RIGHT = 8'h07;
    localparam key_t KEY_CCW   = 8'h14;
    localparam key_t KEY_CW    = 8'h08;

endpackage

`default_nettype wire
